/* hw/riscv_isa_pkg.sv */
`default_nettype none

package riscv_isa_pkg;

    // field widths of the base instruction format
    localparam int INSTR_W  = 32;
    localparam int OPCODE_W = 7;
    localparam int FUNCT3_W = 3;
    localparam int FUNCT7_W = 7;

    typedef logic [INSTR_W-1:0]  instr_t;
    typedef logic [OPCODE_W-1:0] opcode_t;
    typedef logic [FUNCT3_W-1:0] funct3_t;
    typedef logic [FUNCT7_W-1:0] funct7_t;

    // major opcodes handled here
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;

    // funct3, shared by OP and OP-IMM
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // alternate encoding selects SUB and SRA/SRAI
    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;

endpackage

`default_nettype wire

/* hw/exec_pkg.sv */
`default_nettype none

package exec_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 1 << REG_ADDR_W;

    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // operations the ALU can carry out
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_t;

endpackage

`default_nettype wire

/* hw/alu_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_decoder
    import riscv_isa_pkg::*;
    import exec_pkg::*;
(
    input  instr_t    instr,
    output alu_op_t   alu_op,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output reg_addr_t rd,
    output data_t     imm,
    output logic      use_imm,
    output logic      legal
);

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    logic    is_op;
    logic    is_op_imm;
    logic    alt;
    logic    base;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign rd  = instr[11:7];
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];

    // I-type immediate, sign extended
    assign imm = {{(DATA_W-12){instr[31]}}, instr[31:20]};

    assign is_op     = (opcode == OPC_OP);
    assign is_op_imm = (opcode == OPC_OP_IMM);
    assign use_imm   = is_op_imm;

    assign alt  = (funct7 == F7_ALT);
    assign base = (funct7 == F7_BASE);

    always_comb begin
        alu_op = ALU_ADD;
        legal  = 1'b0;
        if (is_op || is_op_imm) begin
            case (funct3)
                F3_ADD_SUB: begin
                    // SUB only exists in register form
                    if (is_op && alt) begin
                        alu_op = ALU_SUB;
                        legal  = 1'b1;
                    end else begin
                        alu_op = ALU_ADD;
                        legal  = is_op_imm || base;
                    end
                end
                F3_SLL: begin
                    alu_op = ALU_SLL;
                    legal  = base;
                end
                F3_SRL_SRA: begin
                    alu_op = alt ? ALU_SRA : ALU_SRL;
                    legal  = base || alt;
                end
                F3_SLT: begin
                    alu_op = ALU_SLT;
                    legal  = is_op_imm || base;
                end
                F3_SLTU: begin
                    alu_op = ALU_SLTU;
                    legal  = is_op_imm || base;
                end
                F3_XOR: begin
                    alu_op = ALU_XOR;
                    legal  = is_op_imm || base;
                end
                F3_OR: begin
                    alu_op = ALU_OR;
                    legal  = is_op_imm || base;
                end
                F3_AND: begin
                    alu_op = ALU_AND;
                    legal  = is_op_imm || base;
                end
                default: begin
                    legal = 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile
    import exec_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t raddr_a,
    input  reg_addr_t raddr_b,
    output data_t     rdata_a,
    output data_t     rdata_b,
    input  logic      we,
    input  reg_addr_t waddr,
    input  data_t     wdata
);

    // x0 is cleared on reset and never written
    data_t regs [0:NUM_REGS-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

    // x0 reads zero even after a write aimed at it
    a_x0_zero_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        (raddr_a == '0) |-> (rdata_a == '0)
    ) else $error("regfile: x0 read on port a returned nonzero data");

    a_x0_zero_b: assert property (
        @(posedge clk) disable iff (!rst_n)
        (raddr_b == '0) |-> (rdata_b == '0)
    ) else $error("regfile: x0 read on port b returned nonzero data");

endmodule

`default_nettype wire

/* hw/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu
    import exec_pkg::*;
#(
    parameter int ALU_LATENCY = 4
) (
    input  logic    clk,
    input  logic    rst_n,
    input  data_t   operand1,
    input  data_t   operand2,
    input  logic    req_valid,
    input  alu_op_t alu_op,
    output data_t   result,
    output logic    resp_valid
);

    localparam int CNT_W = (ALU_LATENCY > 0) ? $clog2(ALU_LATENCY + 1) : 1;
    localparam logic [CNT_W-1:0] CNT_INIT = CNT_W'(ALU_LATENCY);

    typedef enum logic [1:0] {
        IDLE,
        PROCESSING,
        FINISH
    } state_t;

    state_t           state;
    state_t           next_state;
    logic [CNT_W-1:0] count;
    logic [4:0]       shamt;
    logic             lt_signed;
    logic             lt_unsigned;
    logic             done;

    assign shamt       = operand2[4:0];
    assign lt_signed   = $signed(operand1) < $signed(operand2);
    assign lt_unsigned = operand1 < operand2;
    assign done        = (state == PROCESSING) && (count == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // countdown while processing, reloaded otherwise
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= CNT_INIT;
        end else if (state == PROCESSING) begin
            count <= count - 1'b1;
        end else begin
            count <= CNT_INIT;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (req_valid) begin
                    next_state = PROCESSING;
                end
            end
            PROCESSING: begin
                if (count == '0) begin
                    next_state = FINISH;
                end
            end
            FINISH: begin
                next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (done) begin
            case (alu_op)
                ALU_ADD:  result <= operand1 + operand2;
                ALU_SUB:  result <= operand1 - operand2;
                ALU_AND:  result <= operand1 & operand2;
                ALU_OR:   result <= operand1 | operand2;
                ALU_XOR:  result <= operand1 ^ operand2;
                ALU_SLT:  result <= {{(DATA_W-1){1'b0}}, lt_signed};
                ALU_SLTU: result <= {{(DATA_W-1){1'b0}}, lt_unsigned};
                ALU_SLL:  result <= operand1 << shamt;
                ALU_SRL:  result <= operand1 >> shamt;
                ALU_SRA:  result <= data_t'($signed(operand1) >>> shamt);
                default:  result <= '0;
            endcase
        end
    end

    assign resp_valid = (state == FINISH);

    // requester must hold its request until the response
    a_req_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == PROCESSING) |-> ($stable(operand1) && $stable(operand2) && $stable(alu_op))
    ) else $error("alu: request changed while processing");

endmodule

`default_nettype wire

/* hw/issue_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_ctrl
    import exec_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      instr_valid,
    input  logic      legal,
    input  alu_op_t   alu_op_in,
    input  reg_addr_t rd_in,
    input  data_t     rs1_data,
    input  data_t     rs2_data,
    input  data_t     imm,
    input  logic      use_imm,
    output logic      busy,
    output logic      illegal,
    output data_t     operand_a,
    output data_t     operand_b,
    output alu_op_t   alu_op,
    output logic      req_valid,
    input  data_t     result,
    input  logic      resp_valid,
    output logic      we,
    output reg_addr_t waddr,
    output data_t     wdata,
    output logic      wb_valid,
    output reg_addr_t wb_rd,
    output data_t     wb_data
);

    typedef enum logic {
        IDLE,
        WAIT
    } state_t;

    state_t    state;
    reg_addr_t rd_q;
    logic      accept;

    // strobes while busy are dropped
    assign accept = instr_valid && legal && (state == IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            req_valid <= 1'b0;
            illegal   <= 1'b0;
        end else begin
            req_valid <= accept;
            illegal   <= instr_valid && !legal && (state == IDLE);
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= WAIT;
                    end
                end
                WAIT: begin
                    if (resp_valid) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // operands held for the whole ALU request
    always_ff @(posedge clk) begin
        if (accept) begin
            operand_a <= rs1_data;
            operand_b <= use_imm ? imm : rs2_data;
            alu_op    <= alu_op_in;
            rd_q      <= rd_in;
        end
    end

    assign busy     = (state == WAIT);
    assign wb_valid = (state == WAIT) && resp_valid;
    assign wb_rd    = rd_q;
    assign wb_data  = result;

    // write port mirrors the write-back report
    assign we    = wb_valid;
    assign waddr = rd_q;
    assign wdata = result;

    a_no_stray_resp: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == IDLE) |-> !resp_valid
    ) else $error("issue_ctrl: ALU response without a request");

endmodule

`default_nettype wire

/* hw/exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_top
    import riscv_isa_pkg::*;
    import exec_pkg::*;
#(
    parameter int ALU_LATENCY = 4
) (
    input  logic      clk,
    input  logic      rst_n,
    input  instr_t    instr,
    input  logic      instr_valid,
    output logic      busy,
    output logic      wb_valid,
    output reg_addr_t wb_rd,
    output data_t     wb_data,
    output logic      illegal
);

    // decoded fields
    alu_op_t   dec_op;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    data_t     imm;
    logic      use_imm;
    logic      legal;

    // register file
    data_t     rs1_data;
    data_t     rs2_data;
    logic      we;
    reg_addr_t waddr;
    data_t     wdata;

    // ALU request and response
    data_t     operand_a;
    data_t     operand_b;
    alu_op_t   alu_op;
    logic      req_valid;
    data_t     result;
    logic      resp_valid;

    alu_decoder u_decoder (
        .instr   (instr),
        .alu_op  (dec_op),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd),
        .imm     (imm),
        .use_imm (use_imm),
        .legal   (legal)
    );

    regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .raddr_a (rs1),
        .raddr_b (rs2),
        .rdata_a (rs1_data),
        .rdata_b (rs2_data),
        .we      (we),
        .waddr   (waddr),
        .wdata   (wdata)
    );

    issue_ctrl u_issue (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .legal       (legal),
        .alu_op_in   (dec_op),
        .rd_in       (rd),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .imm         (imm),
        .use_imm     (use_imm),
        .busy        (busy),
        .illegal     (illegal),
        .operand_a   (operand_a),
        .operand_b   (operand_b),
        .alu_op      (alu_op),
        .req_valid   (req_valid),
        .result      (result),
        .resp_valid  (resp_valid),
        .we          (we),
        .waddr       (waddr),
        .wdata       (wdata),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    alu #(
        .ALU_LATENCY (ALU_LATENCY)
    ) u_alu (
        .clk        (clk),
        .rst_n      (rst_n),
        .operand1   (operand_a),
        .operand2   (operand_b),
        .req_valid  (req_valid),
        .alu_op     (alu_op),
        .result     (result),
        .resp_valid (resp_valid)
    );

endmodule

`default_nettype wire

/* testbench/tb_exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_exec_top
    import riscv_isa_pkg::*;
    import exec_pkg::*;
;

    localparam int ALU_LATENCY    = 4;
    localparam int CLK_PERIOD     = 8;
    localparam int NUM_INSTR      = 150;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * (ALU_LATENCY + 10) + 100;

    logic      clk = 1'b0;
    logic      rst_n;
    instr_t    instr;
    logic      instr_valid;
    logic      busy;
    logic      wb_valid;
    reg_addr_t wb_rd;
    data_t     wb_data;
    logic      illegal;

    int        seed = 34;
    int        value_errs = 0;
    int        other_errs = 0;
    data_t     model [0:NUM_REGS-1];
    reg_addr_t exp_rd_q [$];
    data_t     exp_data_q [$];

    exec_top #(
        .ALU_LATENCY (ALU_LATENCY)
    ) DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .busy        (busy),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .illegal     (illegal)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic instr_t r_type_word(funct7_t f7, funct3_t f3, reg_addr_t rd,
                                           reg_addr_t rs1, reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic instr_t i_type_word(logic [11:0] imm12, funct3_t f3, reg_addr_t rd,
                                           reg_addr_t rs1);
        return {imm12, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic reg_addr_t pick_reg(bit nonzero);
        int        r;
        reg_addr_t a;
        r = $random(seed);
        a = reg_addr_t'(r);
        if (nonzero && a == '0) begin
            a = 5'd1;
        end
        return a;
    endfunction

    // expected write-back value from the model registers
    function automatic data_t expected_result(instr_t ins);
        opcode_t    opc;
        funct3_t    f3;
        funct7_t    f7;
        data_t      a;
        data_t      b;
        logic [4:0] sh;
        data_t      res;
        opc = ins[6:0];
        f3  = ins[14:12];
        f7  = ins[31:25];
        a   = model[ins[19:15]];
        if (opc == OPC_OP_IMM) begin
            b = {{20{ins[31]}}, ins[31:20]};
        end else begin
            b = model[ins[24:20]];
        end
        sh = b[4:0];
        case (f3)
            F3_ADD_SUB: res = (opc == OPC_OP && f7 == F7_ALT) ? a - b : a + b;
            F3_SLL:     res = a << sh;
            F3_SLT:     res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_SLTU:    res = (a < b) ? 32'd1 : 32'd0;
            F3_XOR:     res = a ^ b;
            F3_SRL_SRA: res = f7[5] ? data_t'($signed(a) >>> sh) : a >> sh;
            F3_OR:      res = a | b;
            default:    res = a & b;
        endcase
        return res;
    endfunction

    task automatic wait_idle();
        while (busy) begin
            @(negedge clk);
        end
    endtask

    // one legal instruction, start to finish
    task automatic execute(instr_t ins);
        exp_rd_q.push_back(ins[11:7]);
        exp_data_q.push_back(expected_result(ins));
        @(posedge clk);
        #1;
        instr       = ins;
        instr_valid = 1'b1;
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        assert (busy) else begin
            $display("busy did not rise after an accepted instruction");
            other_errs++;
        end
        wait_idle();
    endtask

    task automatic send_illegal(instr_t ins);
        @(posedge clk);
        #1;
        instr       = ins;
        instr_valid = 1'b1;
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        @(negedge clk);
        assert (illegal) else begin
            $display("illegal did not pulse for an unsupported encoding");
            other_errs++;
        end
        assert (!busy) else begin
            $display("busy rose for an illegal instruction");
            other_errs++;
        end
        // room for a stray write-back to show up
        repeat (ALU_LATENCY + 4) @(negedge clk);
    endtask

    always @(negedge clk) begin : compare
        reg_addr_t rd_e;
        data_t     data_e;
        if (rst_n && wb_valid) begin
            assert (exp_rd_q.size() > 0) else begin
                $display("write-back reported with no instruction outstanding");
                other_errs++;
            end
            if (exp_rd_q.size() > 0) begin
                rd_e   = exp_rd_q.pop_front();
                data_e = exp_data_q.pop_front();
                assert (wb_rd == rd_e) else begin
                    $display("ERR wb_rd: got 0x%h, expected 0x%h", wb_rd, rd_e);
                    value_errs++;
                end
                assert (wb_data == data_e) else begin
                    $display("ERR wb_data: got 0x%h, expected 0x%h", wb_data, data_e);
                    value_errs++;
                end
                if (rd_e != '0) begin
                    model[rd_e] = data_e;
                end
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        funct3_t    f3;
        funct7_t    f7;
        logic [4:0] sh;
        for (int i = 0; i < NUM_REGS; i++) begin
            model[i] = '0;
        end
        rst_n       = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        assert (!busy && !wb_valid && !illegal) else begin
            $display("outputs not idle after reset");
            other_errs++;
        end
        // registers come out of reset at zero
        execute(r_type_word(F7_BASE, F3_ADD_SUB, 5'd1, 5'd2, 5'd3));

        // load every register through ADDI
        for (int r = 1; r < NUM_REGS; r++) begin
            execute(i_type_word(12'($random(seed)), F3_ADD_SUB, reg_addr_t'(r), 5'd0));
        end

        // shift edge cases, x5 holds 31 and x6 a negative value
        execute(i_type_word(12'd31, F3_ADD_SUB, 5'd5, 5'd0));
        execute(i_type_word(12'h800, F3_ADD_SUB, 5'd6, 5'd0));
        execute(r_type_word(F7_BASE, F3_SLL, 5'd7, 5'd6, 5'd5));
        execute(r_type_word(F7_BASE, F3_SRL_SRA, 5'd8, 5'd6, 5'd5));
        execute(r_type_word(F7_ALT, F3_SRL_SRA, 5'd9, 5'd6, 5'd5));
        execute(r_type_word(F7_BASE, F3_SLL, 5'd10, 5'd6, 5'd0));
        execute(r_type_word(F7_BASE, F3_SRL_SRA, 5'd11, 5'd6, 5'd0));
        execute(r_type_word(F7_ALT, F3_SRL_SRA, 5'd12, 5'd6, 5'd0));

        // random register-register operations
        for (int n = 0; n < 6; n++) begin
            for (int k = 0; k < 10; k++) begin
                f7 = (k == 1 || k == 9) ? F7_ALT : F7_BASE;
                case (k)
                    0, 1:    f3 = F3_ADD_SUB;
                    2:       f3 = F3_AND;
                    3:       f3 = F3_OR;
                    4:       f3 = F3_XOR;
                    5:       f3 = F3_SLT;
                    6:       f3 = F3_SLTU;
                    7:       f3 = F3_SLL;
                    default: f3 = F3_SRL_SRA;
                endcase
                execute(r_type_word(f7, f3, pick_reg(1'b1), pick_reg(1'b0), pick_reg(1'b0)));
            end
        end

        // immediate forms
        for (int n = 0; n < 4; n++) begin
            execute(i_type_word(12'($random(seed)), F3_AND, pick_reg(1'b1), pick_reg(1'b0)));
            execute(i_type_word(12'($random(seed)), F3_OR, pick_reg(1'b1), pick_reg(1'b0)));
            execute(i_type_word(12'($random(seed)), F3_XOR, pick_reg(1'b1), pick_reg(1'b0)));
            execute(i_type_word(12'($random(seed)), F3_SLT, pick_reg(1'b1), pick_reg(1'b0)));
            execute(i_type_word(12'($random(seed)), F3_SLTU, pick_reg(1'b1), pick_reg(1'b0)));
            sh = 5'($random(seed));
            execute(i_type_word({F7_BASE, sh}, F3_SLL, pick_reg(1'b1), pick_reg(1'b0)));
            sh = 5'($random(seed));
            execute(i_type_word({F7_BASE, sh}, F3_SRL_SRA, pick_reg(1'b1), pick_reg(1'b0)));
            sh = 5'($random(seed));
            execute(i_type_word({F7_ALT, sh}, F3_SRL_SRA, pick_reg(1'b1), pick_reg(1'b0)));
        end

        // x0 write is reported but not stored
        execute(i_type_word(12'h123, F3_ADD_SUB, 5'd0, 5'd0));
        execute(r_type_word(F7_BASE, F3_ADD_SUB, 5'd7, 5'd0, 5'd9));

        // second strobe lands while busy and must vanish
        exp_rd_q.push_back(5'd10);
        exp_data_q.push_back(expected_result(r_type_word(F7_BASE, F3_ADD_SUB, 5'd10, 5'd1, 5'd2)));
        @(posedge clk);
        #1;
        instr       = r_type_word(F7_BASE, F3_ADD_SUB, 5'd10, 5'd1, 5'd2);
        instr_valid = 1'b1;
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        @(posedge clk);
        #1;
        assert (busy) else begin
            $display("busy low while an instruction is in flight");
            other_errs++;
        end
        instr       = i_type_word(12'h7ff, F3_ADD_SUB, 5'd10, 5'd0);
        instr_valid = 1'b1;
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        wait_idle();
        repeat (ALU_LATENCY + 4) @(negedge clk);
        execute(r_type_word(F7_BASE, F3_ADD_SUB, 5'd11, 5'd10, 5'd0));

        // store opcode, then OP with a funct7 outside the base set
        send_illegal({7'd0, 5'd2, 5'd1, 3'b010, 5'd4, 7'b0100011});
        send_illegal(r_type_word(7'b0000001, F3_ADD_SUB, 5'd3, 5'd1, 5'd2));
        execute(r_type_word(F7_BASE, F3_ADD_SUB, 5'd12, 5'd3, 5'd0));

        repeat (4) @(negedge clk);
        assert (exp_rd_q.size() == 0) else begin
            $display("write-backs missing at the end of the run");
            other_errs++;
        end
        $display("errors: %0d value, %0d other", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* exec_sim.f */
hw/riscv_isa_pkg.sv
hw/exec_pkg.sv
hw/alu_decoder.sv
hw/regfile.sv
hw/alu.sv
hw/issue_ctrl.sv
hw/exec_top.sv
testbench/tb_exec_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the execute subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f exec_sim.f --top-module tb_exec_top -o sim_exec

out=$(./obj_dir/sim_exec 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
else
    exit 1
fi
